/* hdl/branch_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module branch_predictor (
    input  logic                                      clock,
    input  logic                                      reset,
    input  logic [`ADDR_BITS-1:0]                     fetch_pc,
    input  logic                                      resolve_valid,
    input  logic [`ADDR_BITS-1:0]                     resolve_pc,
    input  logic                                      resolve_taken,
    input  logic [`ADDR_BITS-1:0]                     resolve_target,
    output logic [`FETCH_WIDTH-1:0][`ADDR_BITS-1:0]   slot_addr,
    output logic [`FETCH_WIDTH-1:0]                   slot_valid,
    output logic [`FETCH_WIDTH-1:0]                   slot_taken,
    output logic [`FETCH_WIDTH-1:0][`ADDR_BITS-1:0]   slot_target
);

    // BTB storage, only the valid bits are cleared by reset
    logic [`BTB_ENTRIES-1:0]               btb_valid;
    logic [fetch_pkg::BTB_TAG_BITS-1:0]    btb_tags    [`BTB_ENTRIES];
    logic [`ADDR_BITS-1:0]                 btb_targets [`BTB_ENTRIES];

    logic [`FETCH_WIDTH-1:0]               btb_hit;
    logic [`ADDR_BITS-1:0]                 walk_addr;
    logic                                  taken_seen;

    logic [fetch_pkg::BTB_INDEX_BITS-1:0]  res_index;
    logic                                  res_hit;

    // walk the slots in order, each one starts where the previous one goes next
    always_comb begin
        walk_addr  = fetch_pc;
        taken_seen = 1'b0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            slot_addr[i] = walk_addr;
            btb_hit[i]   = btb_valid[fetch_pkg::btb_index(walk_addr)]
                        && (btb_tags[fetch_pkg::btb_index(walk_addr)]
                            == fetch_pkg::btb_tag(walk_addr));
            // anything after a predicted taken slot is off path
            slot_valid[i] = !taken_seen;
            slot_taken[i] = btb_hit[i] && !taken_seen;
            if (btb_hit[i]) begin
                slot_target[i] = btb_targets[fetch_pkg::btb_index(walk_addr)];
            end else begin
                slot_target[i] = walk_addr + `ADDR_BITS'(4);
            end
            taken_seen = taken_seen || btb_hit[i];
            walk_addr  = slot_target[i];
        end
    end

    // training
    assign res_index = fetch_pkg::btb_index(resolve_pc);
    assign res_hit   = btb_valid[res_index]
                    && (btb_tags[res_index] == fetch_pkg::btb_tag(resolve_pc));

    always_ff @(posedge clock) begin
        if (reset) begin
            btb_valid <= '0;
        end else if (resolve_valid) begin
            if (resolve_taken) begin
                btb_valid[res_index] <= 1'b1;
            end else if (res_hit) begin
                // not taken after all, drop the entry
                btb_valid[res_index] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (resolve_valid && resolve_taken) begin
            btb_tags[res_index]    <= fetch_pkg::btb_tag(resolve_pc);
            btb_targets[res_index] <= resolve_target;
        end
    end

    slot0_valid: assert property (
        @(posedge clock) disable iff (reset)
        slot_valid[0]
    ) else $error("slot 0 invalid at fetch pc %h", fetch_pc);

endmodule

`default_nettype wire

/* hdl/fetch_align.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_align (
    input  logic [`FETCH_WIDTH-1:0][`ADDR_BITS-1:0]   slot_addr,
    input  logic [`FETCH_WIDTH-1:0]                   slot_valid,
    input  logic [`FETCH_WIDTH-1:0]                   slot_taken,
    input  logic [`FETCH_WIDTH-1:0][`ADDR_BITS-1:0]   slot_target,
    input  logic [`FETCH_WIDTH-1:0]                   hit,
    input  mem_pkg::mem_block_u [`FETCH_WIDTH-1:0]    block,
    input  logic                                      squash,
    output logic [`FETCH_WIDTH-1:0]                   if_valid,
    output logic [`FETCH_WIDTH-1:0][`ADDR_BITS-1:0]   if_pc,
    output logic [`FETCH_WIDTH-1:0][31:0]             if_inst,
    output logic [`FETCH_WIDTH-1:0]                   if_predict_taken,
    output logic [`FETCH_WIDTH-1:0][`ADDR_BITS-1:0]   if_predict_target,
    output logic [`COUNT_BITS-1:0]                    deliver_count,
    output logic [`ADDR_BITS-1:0]                     next_addr
);

    logic chain_ok;

    // delivered slots always form a prefix
    always_comb begin
        chain_ok      = !squash;
        deliver_count = '0;
        next_addr     = slot_addr[0];
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if_valid[i] = chain_ok && slot_valid[i] && hit[i];
            chain_ok    = if_valid[i];
            if (if_valid[i]) begin
                deliver_count = deliver_count + 1'b1;
                // target for a taken slot, pc + 4 otherwise
                next_addr     = slot_target[i];
            end
            if_pc[i]             = slot_addr[i];
            if_inst[i]           = if_valid[i] ? block[i].words[slot_addr[i][2]]
                                               : fetch_pkg::NOP_INST;
            if_predict_taken[i]  = if_valid[i] && slot_taken[i];
            if_predict_target[i] = slot_target[i];
        end
    end

endmodule

`default_nettype wire

/* hdl/fetch_macros.svh */
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// instructions fetched per cycle
`define FETCH_WIDTH 2

// byte address width
`define ADDR_BITS 32

// cache lines, one 64-bit block each
`define IC_LINES 16

// direct-mapped BTB entries
`define BTB_ENTRIES 8

// memory transaction tag, 0 means refused
`define MEM_TAG_BITS 4

// width of a count from 0 up to the fetch width
`define COUNT_BITS ($clog2(`FETCH_WIDTH + 1))

`endif

/* hdl/fetch_pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_pc_gen (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     resolve_mispredict,
    input  logic [`ADDR_BITS-1:0]    resolve_target,
    input  logic [`COUNT_BITS-1:0]   deliver_count,
    input  logic [`ADDR_BITS-1:0]    next_addr,
    output logic [`ADDR_BITS-1:0]    fetch_pc
);

    logic [`ADDR_BITS-1:0] pc_next;

    // priority
    //   1. mispredict redirect from the back end
    //   2. next address from the aligner, which already holds
    //      the predicted target when a taken slot was delivered
    //   3. hold while slot 0 waits on a miss
    always_comb begin
        if (resolve_mispredict) begin
            pc_next = resolve_target;
        end else if (deliver_count != '0) begin
            pc_next = next_addr;
        end else begin
            pc_next = fetch_pc;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_pc <= '0;
        end else begin
            pc_next_check: assert (pc_next[1:0] == 2'b00)
                else $error("next fetch pc %h is not word aligned", pc_next);
            fetch_pc <= pc_next;
        end
    end

    // the aligner can never report more slots than are fetched
    count_in_range: assert property (
        @(posedge clock) disable iff (reset)
        deliver_count <= `FETCH_WIDTH
    ) else $error("deliver_count %0d exceeds fetch width", deliver_count);

endmodule

`default_nettype wire

/* hdl/fetch_pkg.sv */
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

    // addi x0, x0, 0
    localparam logic [31:0] NOP_INST = 32'h0000_0013;

    // cache lines hold 8 bytes, so the index starts at bit 3
    localparam int IC_INDEX_BITS = $clog2(`IC_LINES);
    localparam int IC_TAG_BITS   = `ADDR_BITS - 3 - IC_INDEX_BITS;

    // BTB is indexed per instruction word
    localparam int BTB_INDEX_BITS = $clog2(`BTB_ENTRIES);
    localparam int BTB_TAG_BITS   = `ADDR_BITS - 2 - BTB_INDEX_BITS;

    function automatic logic [IC_INDEX_BITS-1:0] ic_index(input logic [`ADDR_BITS-1:0] addr);
        return addr[3 +: IC_INDEX_BITS];
    endfunction

    function automatic logic [IC_TAG_BITS-1:0] ic_tag(input logic [`ADDR_BITS-1:0] addr);
        return addr[`ADDR_BITS-1 -: IC_TAG_BITS];
    endfunction

    function automatic logic [BTB_INDEX_BITS-1:0] btb_index(input logic [`ADDR_BITS-1:0] addr);
        return addr[2 +: BTB_INDEX_BITS];
    endfunction

    function automatic logic [BTB_TAG_BITS-1:0] btb_tag(input logic [`ADDR_BITS-1:0] addr);
        return addr[`ADDR_BITS-1 -: BTB_TAG_BITS];
    endfunction

endpackage

`default_nettype wire

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_unit (
    input  logic                                      clock,
    input  logic                                      reset,

    // branch resolution from the back end
    input  logic                                      resolve_valid,
    input  logic [`ADDR_BITS-1:0]                     resolve_pc,
    input  logic                                      resolve_taken,
    input  logic [`ADDR_BITS-1:0]                     resolve_target,
    input  logic                                      resolve_mispredict,

    // memory bus
    output logic [1:0]                                mem_command,
    output logic [`ADDR_BITS-1:0]                     mem_addr,
    input  logic [`MEM_TAG_BITS-1:0]                  mem_transaction_tag,
    input  logic [63:0]                               mem_data,
    input  logic [`MEM_TAG_BITS-1:0]                  mem_data_tag,

    // fetched slots
    output logic [`FETCH_WIDTH-1:0]                   if_valid,
    output logic [`FETCH_WIDTH-1:0][`ADDR_BITS-1:0]   if_pc,
    output logic [`FETCH_WIDTH-1:0][31:0]             if_inst,
    output logic [`FETCH_WIDTH-1:0]                   if_predict_taken,
    output logic [`FETCH_WIDTH-1:0][`ADDR_BITS-1:0]   if_predict_target
);

    logic [`ADDR_BITS-1:0]                    fetch_pc;
    logic [`FETCH_WIDTH-1:0][`ADDR_BITS-1:0]  slot_addr;
    logic [`FETCH_WIDTH-1:0]                  slot_valid;
    logic [`FETCH_WIDTH-1:0]                  slot_taken;
    logic [`FETCH_WIDTH-1:0][`ADDR_BITS-1:0]  slot_target;
    logic [`FETCH_WIDTH-1:0]                  hit;
    mem_pkg::mem_block_u [`FETCH_WIDTH-1:0]   block;
    logic [`COUNT_BITS-1:0]                   deliver_count;
    logic [`ADDR_BITS-1:0]                    next_addr;

    fetch_pc_gen pc_gen (
        .clock              (clock),
        .reset              (reset),
        .resolve_mispredict (resolve_mispredict),
        .resolve_target     (resolve_target),
        .deliver_count      (deliver_count),
        .next_addr          (next_addr),
        .fetch_pc           (fetch_pc)
    );

    branch_predictor bp (
        .clock          (clock),
        .reset          (reset),
        .fetch_pc       (fetch_pc),
        .resolve_valid  (resolve_valid),
        .resolve_pc     (resolve_pc),
        .resolve_taken  (resolve_taken),
        .resolve_target (resolve_target),
        .slot_addr      (slot_addr),
        .slot_valid     (slot_valid),
        .slot_taken     (slot_taken),
        .slot_target    (slot_target)
    );

    // a mispredict also cancels any load the bus has not taken yet
    icache ic (
        .clock               (clock),
        .reset               (reset),
        .slot_addr           (slot_addr),
        .slot_valid          (slot_valid),
        .flush               (resolve_mispredict),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data            (mem_data),
        .mem_data_tag        (mem_data_tag),
        .hit                 (hit),
        .block               (block),
        .mem_command         (mem_command),
        .mem_addr            (mem_addr)
    );

    fetch_align align (
        .slot_addr         (slot_addr),
        .slot_valid        (slot_valid),
        .slot_taken        (slot_taken),
        .slot_target       (slot_target),
        .hit               (hit),
        .block             (block),
        .squash            (resolve_mispredict),
        .if_valid          (if_valid),
        .if_pc             (if_pc),
        .if_inst           (if_inst),
        .if_predict_taken  (if_predict_taken),
        .if_predict_target (if_predict_target),
        .deliver_count     (deliver_count),
        .next_addr         (next_addr)
    );

endmodule

`default_nettype wire

/* hdl/icache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module icache (
    input  logic                                      clock,
    input  logic                                      reset,
    input  logic [`FETCH_WIDTH-1:0][`ADDR_BITS-1:0]   slot_addr,
    input  logic [`FETCH_WIDTH-1:0]                   slot_valid,
    input  logic                                      flush,
    input  logic [`MEM_TAG_BITS-1:0]                  mem_transaction_tag,
    input  logic [63:0]                               mem_data,
    input  logic [`MEM_TAG_BITS-1:0]                  mem_data_tag,
    output logic [`FETCH_WIDTH-1:0]                   hit,
    output mem_pkg::mem_block_u [`FETCH_WIDTH-1:0]    block,
    output logic [1:0]                                mem_command,
    output logic [`ADDR_BITS-1:0]                     mem_addr
);

    // line storage
    logic [`IC_LINES-1:0]                  line_valid;
    logic [fetch_pkg::IC_TAG_BITS-1:0]     line_tag  [`IC_LINES];
    mem_pkg::mem_block_u                   line_data [`IC_LINES];

    // request waiting for the bus to accept it
    logic                                  req_active;
    logic [`ADDR_BITS-1:0]                 req_addr;

    // accepted request waiting for its data
    logic                                  fill_pending;
    logic [`MEM_TAG_BITS-1:0]              fill_tag;
    logic [`ADDR_BITS-1:0]                 fill_addr;
    logic [fetch_pkg::IC_INDEX_BITS-1:0]   fill_index;

    logic                                  miss_found;
    logic [`ADDR_BITS-1:0]                 miss_addr;
    logic                                  start_req;
    logic                                  accepted;
    logic                                  fill_done;

    // tag compare on every port
    // descending walk so the lowest missing slot is the one requested
    always_comb begin
        miss_found = 1'b0;
        miss_addr  = '0;
        for (int i = `FETCH_WIDTH - 1; i >= 0; i--) begin
            hit[i]   = slot_valid[i]
                    && line_valid[fetch_pkg::ic_index(slot_addr[i])]
                    && (line_tag[fetch_pkg::ic_index(slot_addr[i])]
                        == fetch_pkg::ic_tag(slot_addr[i]));
            block[i] = line_data[fetch_pkg::ic_index(slot_addr[i])];
            if (slot_valid[i] && !hit[i]) begin
                miss_found = 1'b1;
                miss_addr  = {slot_addr[i][`ADDR_BITS-1:3], 3'b000};
            end
        end
    end

    // one miss at a time, nothing new while a redirect is under way
    assign start_req = !req_active && !fill_pending && miss_found && !flush;
    assign accepted  = req_active && (mem_transaction_tag != '0);
    assign fill_done = fill_pending && (mem_data_tag == fill_tag);

    assign mem_command = req_active ? mem_pkg::BUS_LOAD : mem_pkg::BUS_NONE;
    assign mem_addr    = req_active ? req_addr : '0;
    assign fill_index  = fetch_pkg::ic_index(fill_addr);

    always_ff @(posedge clock) begin
        if (reset) begin
            req_active   <= 1'b0;
            fill_pending <= 1'b0;
        end else begin
            if (accepted) begin
                req_active   <= 1'b0;
                fill_pending <= 1'b1;
            end else if (flush) begin
                // refused so far and now off path
                req_active <= 1'b0;
            end else if (start_req) begin
                req_active <= 1'b1;
            end
            if (fill_done) begin
                fill_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start_req) begin
            req_addr <= miss_addr;
        end
        if (accepted) begin
            fill_tag  <= mem_transaction_tag;
            fill_addr <= req_addr;
        end
    end

    // fill lands on the matching edge, hits from the next cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (fill_done) begin
            line_valid[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill_done) begin
            line_tag[fill_index]        <= fetch_pkg::ic_tag(fill_addr);
            line_data[fill_index].dword <= mem_data;
        end
    end

    no_req_while_pending: assert property (
        @(posedge clock) disable iff (reset)
        fill_pending |-> (mem_command == mem_pkg::BUS_NONE)
    ) else $error("load issued while tag %h still pending", fill_tag);

endmodule

`default_nettype wire

/* hdl/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // one memory block
    // the fill path writes it whole, the aligner picks a word by pc bit 2
    typedef union packed {
        logic [63:0]      dword;
        logic [1:0][31:0] words;
    } mem_block_u;

    // bus command codes
    localparam logic [1:0] BUS_NONE = 2'h0;
    localparam logic [1:0] BUS_LOAD = 2'h1;

endpackage

`default_nettype wire

/* list.f */
+incdir+hdl
hdl/mem_pkg.sv
hdl/fetch_pkg.sv
hdl/fetch_pc_gen.sv
hdl/branch_predictor.sv
hdl/icache.sv
hdl/fetch_align.sv
hdl/fetch_unit.sv
verif/imem_model.sv
verif/fetch_tb.sv

/* verif/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_tb;

    localparam int ROWS         = 12;
    localparam int WAIT_LIMIT   = 60;
    localparam logic [31:0] KEY = 32'h1357_9bdf;

    logic                                     clock;
    logic                                     reset;
    logic                                     resolve_valid;
    logic [`ADDR_BITS-1:0]                    resolve_pc;
    logic                                     resolve_taken;
    logic [`ADDR_BITS-1:0]                    resolve_target;
    logic                                     resolve_mispredict;
    logic [1:0]                               mem_command;
    logic [`ADDR_BITS-1:0]                    mem_addr;
    logic [`MEM_TAG_BITS-1:0]                 mem_transaction_tag;
    logic [63:0]                              mem_data;
    logic [`MEM_TAG_BITS-1:0]                 mem_data_tag;
    logic [`FETCH_WIDTH-1:0]                  if_valid;
    logic [`FETCH_WIDTH-1:0][`ADDR_BITS-1:0]  if_pc;
    logic [`FETCH_WIDTH-1:0][31:0]            if_inst;
    logic [`FETCH_WIDTH-1:0]                  if_predict_taken;
    logic [`FETCH_WIDTH-1:0][`ADDR_BITS-1:0]  if_predict_target;

    // step table with the resolve to apply and the next valid slot 0 expected
    logic        row_valid      [ROWS];
    logic [31:0] row_pc         [ROWS];
    logic        row_taken      [ROWS];
    logic [31:0] row_target     [ROWS];
    logic        row_mispredict [ROWS];
    logic [31:0] row_exp_pc     [ROWS];
    logic        row_exp_taken  [ROWS];
    logic [31:0] row_exp_target [ROWS];

    int          mismatch_count;
    int          other_count;
    logic [31:0] expect_pc;

    fetch_unit UUT (
        .clock               (clock),
        .reset               (reset),
        .resolve_valid       (resolve_valid),
        .resolve_pc          (resolve_pc),
        .resolve_taken       (resolve_taken),
        .resolve_target      (resolve_target),
        .resolve_mispredict  (resolve_mispredict),
        .mem_command         (mem_command),
        .mem_addr            (mem_addr),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data            (mem_data),
        .mem_data_tag        (mem_data_tag),
        .if_valid            (if_valid),
        .if_pc               (if_pc),
        .if_inst             (if_inst),
        .if_predict_taken    (if_predict_taken),
        .if_predict_target   (if_predict_target)
    );

    imem_model #(.REPLY_DELAY(3)) memory (
        .clock               (clock),
        .reset               (reset),
        .mem_command         (mem_command),
        .mem_addr            (mem_addr),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data            (mem_data),
        .mem_data_tag        (mem_data_tag)
    );

    always #50 clock = ~clock;

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return {2'b00, addr[31:2]} ^ KEY;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        mismatch_count++;
        $display("ERR %s got %h expected %h", name, got, expected);
    endtask

    task automatic report_failure(input string what);
        other_count++;
        $display("%s", what);
    endtask

    task automatic drive_resolve(input logic valid, input logic [31:0] pc, input logic taken,
                                 input logic [31:0] target, input logic mispredict);
        resolve_valid      <= valid;
        resolve_pc         <= pc;
        resolve_taken      <= taken;
        resolve_target     <= target;
        resolve_mispredict <= mispredict;
    endtask

    task automatic load_row(input int r, input logic valid, input logic [31:0] pc,
                            input logic taken, input logic [31:0] target,
                            input logic mispredict, input logic [31:0] exp_pc,
                            input logic exp_taken, input logic [31:0] exp_target);
        row_valid[r]      = valid;
        row_pc[r]         = pc;
        row_taken[r]      = taken;
        row_target[r]     = target;
        row_mispredict[r] = mispredict;
        row_exp_pc[r]     = exp_pc;
        row_exp_taken[r]  = exp_taken;
        row_exp_target[r] = exp_target;
    endtask

    // per cycle check of the squash and of the delivered slots in order
    always @(negedge clock) begin
        if (reset) begin
            expect_pc = '0;
        end else if (resolve_mispredict) begin
            assert (if_valid == '0)
                else report_mismatch("if_valid", if_valid, 32'h0);
            expect_pc = resolve_target;
        end else if (if_valid != '0) begin
            assert (if_pc[0] == expect_pc)
                else report_mismatch("if_pc[0]", if_pc[0], expect_pc);
            // slot 1 shares the block of a not taken slot 0 in the lower word
            if (if_valid[0] && !if_predict_taken[0] && !if_pc[0][2]) begin
                assert (if_valid[1])
                    else report_mismatch("if_valid[1]", if_valid[1], 32'h1);
            end
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                if (if_valid[i]) begin
                    assert (if_inst[i] == expected_word(if_pc[i]))
                        else report_mismatch($sformatf("if_inst[%0d]", i), if_inst[i],
                                             expected_word(if_pc[i]));
                    if (i > 0) begin
                        assert (if_valid[i-1] && !if_predict_taken[i-1])
                            else report_failure($sformatf(
                                "slot %0d was delivered after a taken or missing slot", i));
                        assert (if_pc[i] == if_pc[i-1] + 32'd4)
                            else report_mismatch($sformatf("if_pc[%0d]", i), if_pc[i],
                                                 if_pc[i-1] + 32'd4);
                    end
                    expect_pc = if_predict_taken[i] ? if_predict_target[i] : if_pc[i] + 32'd4;
                end
            end
        end
    end

    // a load asks for the block that holds the current fetch pc
    always @(negedge clock) begin
        if (!reset) begin
            if (mem_command == mem_pkg::BUS_LOAD) begin
                assert (mem_addr == {if_pc[0][31:3], 3'b000})
                    else report_mismatch("mem_addr", mem_addr, {if_pc[0][31:3], 3'b000});
            end else begin
                assert (mem_command == mem_pkg::BUS_NONE)
                    else report_mismatch("mem_command", mem_command, mem_pkg::BUS_NONE);
            end
        end
    end

    initial begin : main_sequence
        int unsigned seed;
        logic [31:0] t1;
        logic [31:0] t2;
        int          wait_count;
        bit          found;
        bit          aborted;

        seed = 32'h73ee;
        void'($urandom(seed));
        clock              = 1'b0;
        reset              = 1'b1;
        resolve_valid      = 1'b0;
        resolve_pc         = '0;
        resolve_taken      = 1'b0;
        resolve_target     = '0;
        resolve_mispredict = 1'b0;
        mismatch_count     = 0;
        other_count        = 0;
        aborted            = 1'b0;

        // doubleword aligned targets well away from the branches at 0x14 and 0x24
        t1 = 32'h0000_0400 + (($urandom % 32) << 3);
        t2 = 32'h0000_0800 + (($urandom % 32) << 3);

        load_row(0,  0, 0,     0, 0,     0, 32'h00, 0, 0);
        load_row(1,  0, 0,     0, 0,     0, 32'h08, 0, 0);
        load_row(2,  0, 0,     0, 0,     0, 32'h10, 0, 0);
        // mispredicted taken branch at 0x14 also trains the BTB
        load_row(3,  1, 32'h14, 1, t1,    1, t1,     0, 0);
        load_row(4,  0, 0,     0, 0,     0, t1 + 8, 0, 0);
        load_row(5,  0, 0,     0, 32'h14, 1, 32'h14, 1, t1);
        load_row(6,  0, 0,     0, 0,     0, t1,     0, 0);
        // not taken after all so the entry is cleared
        load_row(7,  1, 32'h14, 0, 32'h18, 1, 32'h18, 0, 0);
        load_row(8,  0, 0,     0, 32'h10, 1, 32'h10, 0, 0);
        load_row(9,  0, 0,     0, 0,     0, 32'h18, 0, 0);
        // plain training and then slot 1 takes the branch
        load_row(10, 1, 32'h24, 1, t2,    0, 32'h20, 0, 0);
        load_row(11, 0, 0,     0, 0,     0, t2,     0, 0);

        repeat (2) @(posedge clock);
        reset <= 1'b0;

        @(negedge clock);
        assert (mem_command == mem_pkg::BUS_NONE)
            else report_mismatch("mem_command", mem_command, mem_pkg::BUS_NONE);
        assert (if_valid == '0)
            else report_mismatch("if_valid", if_valid, 32'h0);

        for (int r = 0; r < ROWS && !aborted; r++) begin
            @(posedge clock);
            drive_resolve(row_valid[r], row_pc[r], row_taken[r], row_target[r],
                          row_mispredict[r]);
            found      = 1'b0;
            wait_count = 0;
            while (!found && !aborted) begin
                @(negedge clock);
                if (if_valid[0]) begin
                    found = 1'b1;
                end else if (wait_count >= WAIT_LIMIT) begin
                    report_failure($sformatf("timed out waiting for a valid slot 0 in step %0d",
                                             r));
                    aborted = 1'b1;
                end else begin
                    wait_count++;
                    @(posedge clock);
                    drive_resolve(1'b0, '0, 1'b0, '0, 1'b0);
                end
            end
            if (found) begin
                assert (if_pc[0] == row_exp_pc[r])
                    else report_mismatch("if_pc[0]", if_pc[0], row_exp_pc[r]);
                assert (if_predict_taken[0] == row_exp_taken[r])
                    else report_mismatch("if_predict_taken[0]", if_predict_taken[0],
                                         row_exp_taken[r]);
                if (row_exp_taken[r]) begin
                    assert (if_predict_target[0] == row_exp_target[r])
                        else report_mismatch("if_predict_target[0]", if_predict_target[0],
                                             row_exp_target[r]);
                end
            end
        end

        @(posedge clock);
        drive_resolve(1'b0, '0, 1'b0, '0, 1'b0);
        @(negedge clock);

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/imem_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module imem_model #(
    parameter int REPLY_DELAY = 3
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [1:0]                  mem_command,
    input  logic [`ADDR_BITS-1:0]       mem_addr,
    output logic [`MEM_TAG_BITS-1:0]    mem_transaction_tag,
    output logic [63:0]                 mem_data,
    output logic [`MEM_TAG_BITS-1:0]    mem_data_tag
);

    localparam logic [31:0] WORD_KEY = 32'h1357_9bdf;

    logic [`MEM_TAG_BITS-1:0]    next_tag;
    int                          cycle_count;

    // loads in flight, oldest first
    logic [`MEM_TAG_BITS-1:0]    pend_tag  [$];
    logic [`ADDR_BITS-1:0]       pend_addr [$];
    int                          pend_due  [$];

    function automatic logic [31:0] word_at(input logic [`ADDR_BITS-1:0] addr);
        return {2'b00, addr[31:2]} ^ WORD_KEY;
    endfunction

    // every fifth cycle the bus is busy and refuses, so the retry path runs
    assign mem_transaction_tag = ((mem_command == mem_pkg::BUS_LOAD) && (cycle_count % 5 != 0))
                               ? next_tag : '0;

    always @(posedge clock) begin
        if (reset) begin
            next_tag     <= 'd1;
            cycle_count  <= 0;
            mem_data     <= '0;
            mem_data_tag <= '0;
            pend_tag.delete();
            pend_addr.delete();
            pend_due.delete();
        end else begin
            cycle_count  <= cycle_count + 1;
            mem_data_tag <= '0;
            // reply registered here shows up REPLY_DELAY cycles after the accept
            if (pend_due.size() > 0 && pend_due[0] == cycle_count) begin
                mem_data_tag <= pend_tag[0];
                mem_data     <= {word_at(pend_addr[0] + 32'd4), word_at(pend_addr[0])};
                void'(pend_tag.pop_front());
                void'(pend_addr.pop_front());
                void'(pend_due.pop_front());
            end
            if (mem_transaction_tag != '0) begin
                pend_tag.push_back(mem_transaction_tag);
                pend_addr.push_back({mem_addr[31:3], 3'b000});
                pend_due.push_back(cycle_count + REPLY_DELAY - 1);
                // tag 0 is reserved for a refusal
                next_tag <= (next_tag == '1) ? 'd1 : next_tag + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
